//--- design/classifier_pkg.sv
package classifier_pkg;

	localparam int BEAT_WIDTH = 128;

	typedef logic [7:0] tag_t;

	// fields pulled from the first three beats of a packet
	typedef struct packed {
		logic [15:0] ethertype;
		logic [7:0]  ip_protocol;
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] dst_port;
	} header_t;

	typedef struct packed {
		header_t header;
		tag_t    tag;
	} header_entry_t;

	typedef struct packed {
		logic [1:0] rule;
		tag_t       tag;
	} result_t;

	typedef struct packed {
		header_t value;
		header_t mask;
	} rule_t;

	// ------------------------------
	// rule table, index 0 has the highest priority
	// ------------------------------
	localparam int RULE_COUNT = 4;

	localparam rule_t RULES [RULE_COUNT] = '{
		'{value: '{ethertype: 16'h0800, ip_protocol: 8'd6, src_ip: 32'h0, dst_ip: 32'h0,
				dst_port: 16'd80},
			mask: '{ethertype: 16'hffff, ip_protocol: 8'hff, src_ip: 32'h0, dst_ip: 32'h0,
				dst_port: 16'hffff}},
		'{value: '{ethertype: 16'h0800, ip_protocol: 8'd17, src_ip: 32'h0, dst_ip: 32'h0,
				dst_port: 16'd53},
			mask: '{ethertype: 16'hffff, ip_protocol: 8'hff, src_ip: 32'h0, dst_ip: 32'h0,
				dst_port: 16'hffff}},
		// 10.0.0.0/8
		'{value: '{ethertype: 16'h0800, ip_protocol: 8'd0, src_ip: 32'h0,
				dst_ip: 32'h0a00_0000, dst_port: 16'd0},
			mask: '{ethertype: 16'hffff, ip_protocol: 8'h00, src_ip: 32'h0,
				dst_ip: 32'hff00_0000, dst_port: 16'h0000}},
		// ARP
		'{value: '{ethertype: 16'h0806, ip_protocol: 8'd0, src_ip: 32'h0, dst_ip: 32'h0,
				dst_port: 16'd0},
			mask: '{ethertype: 16'hffff, ip_protocol: 8'h00, src_ip: 32'h0, dst_ip: 32'h0,
				dst_port: 16'h0000}}
	};

	localparam int HEADER_FIFO_DEPTH = 16;
	localparam int RESULT_FIFO_DEPTH = 8;

endpackage

//--- design/header_if.sv
`timescale 1ns/1ns

// one header record plus its tag, valid/ready handshake
interface header_if;

	logic                         valid;
	logic                         ready;
	classifier_pkg::header_entry_t entry;

	// source holds valid and entry until the transfer
	modport source (
		output valid,
		output entry,
		input  ready
	);

	modport sink (
		input  valid,
		input  entry,
		output ready
	);

endinterface

//--- design/header_capture.sv
`timescale 1ns/1ns

module header_capture (
	input  logic                                   clock,
	input  logic                                   rst,
	input  logic [classifier_pkg::BEAT_WIDTH-1:0]  in_data,
	input  logic                                   in_sop,
	input  logic                                   in_eop,
	input  classifier_pkg::tag_t                   in_tag,
	input  logic                                   in_valid,
	output logic                                   in_ready,
	header_if.source                               hdr
);

	logic [1:0] beat_cnt;
	logic [1:0] cur_beat;
	logic       pending;
	logic       skip;
	logic       beat_ok;
	logic       take;
	classifier_pkg::header_entry_t entry;

	// no new beats while a header waits downstream
	assign in_ready = !pending;
	assign beat_ok  = in_valid && in_ready;

	// a sop always restarts the walk at beat 0
	assign cur_beat = in_sop ? 2'd0 : beat_cnt;
	assign take     = beat_ok && (!skip || in_sop);

	assign hdr.valid = pending;
	assign hdr.entry = entry;

	// ------------------------------
	// beat walk and pending flag
	// ------------------------------
	always_ff @(posedge clock) begin
		if (rst) begin
			beat_cnt <= 2'd0;
			pending  <= 1'b0;
			skip     <= 1'b0;
		end else begin
			if (hdr.valid && hdr.ready)
				pending <= 1'b0;
			if (take) begin
				case (cur_beat)
					2'd0: begin
						skip <= 1'b0;
						if (in_eop) begin
							pending  <= 1'b1;
							beat_cnt <= 2'd0;
						end else begin
							beat_cnt <= 2'd1;
						end
					end
					2'd1: begin
						if (in_eop) begin
							pending  <= 1'b1;
							beat_cnt <= 2'd0;
						end else begin
							beat_cnt <= 2'd2;
						end
					end
					default: begin
						// header complete, rest of the packet is dropped
						pending  <= 1'b1;
						beat_cnt <= 2'd0;
						skip     <= !in_eop;
					end
				endcase
			end else if (beat_ok && in_eop) begin
				skip <= 1'b0;
			end
		end
	end

	// ------------------------------
	// field capture, byte 0 in bits 127:120
	// ------------------------------
	always_ff @(posedge clock) begin
		if (take) begin
			case (cur_beat)
				2'd0: begin
					entry.header           <= '0;
					entry.header.ethertype <= in_data[31:16];
					entry.tag              <= in_tag;
				end
				2'd1: begin
					entry.header.ip_protocol   <= in_data[71:64];
					entry.header.src_ip        <= in_data[47:16];
					entry.header.dst_ip[31:16] <= in_data[15:0];
				end
				default: begin
					entry.header.dst_ip[15:0] <= in_data[127:112];
					entry.header.dst_port     <= in_data[95:80];
				end
			endcase
		end
	end

endmodule

//--- design/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 16
) (
	input  logic     clock,
	input  logic     rst,
	input  logic     push_valid,
	input  payload_t push_data,
	output logic     push_ready,
	output logic     pop_valid,
	output payload_t pop_data,
	input  logic     pop_ready
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t           mem [DEPTH];
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W-1:0]   wr_ptr;
	logic [CNT_W-1:0]   count;
	logic               do_push;
	logic               do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign push_ready = (count != CNT_W'(DEPTH));
	assign pop_valid  = (count != '0);
	// show-ahead, head entry always on the pop side
	assign pop_data   = mem[rd_ptr];

	assign do_push = push_valid && push_ready;
	assign do_pop  = pop_valid && pop_ready;

	always_ff @(posedge clock) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

//--- design/rule_matcher.sv
`timescale 1ns/1ns

module rule_matcher (
	input  logic                    clock,
	input  logic                    rst,
	header_if.sink                  hdr,
	output logic                    res_valid,
	output classifier_pkg::result_t res_data,
	input  logic                    res_ready
);

	logic [classifier_pkg::RULE_COUNT-1:0] hits;
	logic [classifier_pkg::RULE_COUNT-1:0] s1_hits;
	logic                                  s1_valid;
	classifier_pkg::tag_t                  s1_tag;
	logic [1:0]                            sel_rule;
	logic                                  sel_none;
	logic                                  s2_valid;
	logic                                  s2_drop;
	logic [1:0]                            s2_rule;
	classifier_pkg::tag_t                  s2_tag;
	logic                                  s1_free;
	logic                                  s2_free;

	// masked equality against every rule
	always_comb begin
		for (int i = 0; i < classifier_pkg::RULE_COUNT; i++) begin
			hits[i] = ((hdr.entry.header ^ classifier_pkg::RULES[i].value)
				& classifier_pkg::RULES[i].mask) == '0;
		end
	end

	// lowest index wins
	always_comb begin
		sel_rule = 2'd0;
		sel_none = 1'b1;
		for (int i = classifier_pkg::RULE_COUNT - 1; i >= 0; i--) begin
			if (s1_hits[i]) begin
				sel_rule = 2'(i);
				sel_none = 1'b0;
			end
		end
	end

	// a drop leaves stage two without a push
	assign s2_free   = !s2_valid || s2_drop || res_ready;
	assign s1_free   = !s1_valid || s2_free;
	assign hdr.ready = s1_free;

	assign res_valid     = s2_valid && !s2_drop;
	assign res_data.rule = s2_rule;
	assign res_data.tag  = s2_tag;

	// ------------------------------
	// pipeline valids
	// ------------------------------
	always_ff @(posedge clock) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (s1_free)
				s1_valid <= hdr.valid;
			if (s2_free)
				s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (s1_free) begin
			s1_hits <= hits;
			s1_tag  <= hdr.entry.tag;
		end
		if (s2_free) begin
			s2_rule <= sel_rule;
			s2_drop <= sel_none;
			s2_tag  <= s1_tag;
		end
	end

endmodule

//--- design/match_block.sv
`timescale 1ns/1ns

module match_block (
	input  logic                                  clock,
	input  logic                                  rst,
	input  logic [classifier_pkg::BEAT_WIDTH-1:0] in_data,
	input  logic                                  in_sop,
	input  logic                                  in_eop,
	input  classifier_pkg::tag_t                  in_tag,
	input  logic                                  in_valid,
	output logic                                  in_ready,
	output logic [1:0]                            out_rule,
	output classifier_pkg::tag_t                  out_tag,
	output logic                                  out_valid,
	input  logic                                  out_ack
);

	header_if cap_to_fifo ();
	header_if fifo_to_match ();

	logic                    match_valid;
	classifier_pkg::result_t match_data;
	logic                    match_ready;
	classifier_pkg::result_t head_result;

	// ------------------------------
	// front end
	// ------------------------------
	header_capture i_header_capture (
		.clock    (clock),
		.rst      (rst),
		.in_data  (in_data),
		.in_sop   (in_sop),
		.in_eop   (in_eop),
		.in_tag   (in_tag),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.hdr      (cap_to_fifo.source)
	);

	sync_fifo #(
		.payload_t (classifier_pkg::header_entry_t),
		.DEPTH     (classifier_pkg::HEADER_FIFO_DEPTH)
	) hdr_fifo (
		.clock      (clock),
		.rst        (rst),
		.push_valid (cap_to_fifo.valid),
		.push_data  (cap_to_fifo.entry),
		.push_ready (cap_to_fifo.ready),
		.pop_valid  (fifo_to_match.valid),
		.pop_data   (fifo_to_match.entry),
		.pop_ready  (fifo_to_match.ready)
	);

	// ------------------------------
	// matcher and result queue
	// ------------------------------
	rule_matcher i_rule_matcher (
		.clock     (clock),
		.rst       (rst),
		.hdr       (fifo_to_match.sink),
		.res_valid (match_valid),
		.res_data  (match_data),
		.res_ready (match_ready)
	);

	sync_fifo #(
		.payload_t (classifier_pkg::result_t),
		.DEPTH     (classifier_pkg::RESULT_FIFO_DEPTH)
	) res_fifo (
		.clock      (clock),
		.rst        (rst),
		.push_valid (match_valid),
		.push_data  (match_data),
		.push_ready (match_ready),
		.pop_valid  (out_valid),
		.pop_data   (head_result),
		.pop_ready  (out_ack)
	);

	assign out_rule = head_result.rule;
	assign out_tag  = head_result.tag;

endmodule

//--- bench/match_block_assert.sv
`timescale 1ns/1ns

module match_block_assert (
	input logic                    clock,
	input logic                    rst,
	input logic                    in_ready,
	input logic                    out_valid,
	input logic                    out_ack,
	input logic [1:0]              out_rule,
	input logic [7:0]              out_tag,
	input logic                    res_push_valid,
	input logic                    res_push_ready,
	input classifier_pkg::result_t res_push_data
);

	// result held until the ack
	result_held: assert property (@(posedge clock) disable iff (rst)
		out_valid && !out_ack |=> out_valid && $stable(out_rule) && $stable(out_tag))
		else $error("result changed before acknowledge");

	// matcher waits with its result while the result FIFO is full
	res_push_held: assert property (@(posedge clock) disable iff (rst)
		res_push_valid && !res_push_ready |=> res_push_valid && $stable(res_push_data))
		else $error("result push lost while FIFO full");

	no_x_outputs: assert property (@(posedge clock) !rst |-> !$isunknown({in_ready, out_valid}))
		else $error("handshake output unknown after reset");

endmodule

bind match_block match_block_assert i_match_block_assert (
	.clock          (clock),
	.rst            (rst),
	.in_ready       (in_ready),
	.out_valid      (out_valid),
	.out_ack        (out_ack),
	.out_rule       (out_rule),
	.out_tag        (out_tag),
	.res_push_valid (match_valid),
	.res_push_ready (match_ready),
	.res_push_data  (match_data)
);

//--- bench/match_block_tb.sv
`timescale 1ns/1ns

module match_block_tb;

	localparam int CLK_PERIOD  = 10;
	localparam int TEST_CYCLES = 2000;

	logic                       clock;
	logic                       rst;
	logic [127:0]               in_data;
	logic                       in_sop;
	logic                       in_eop;
	logic [7:0]                 in_tag;
	logic                       in_valid;
	logic                       in_ready;
	logic [1:0]                 out_rule;
	logic [7:0]                 out_tag;
	logic                       out_valid;
	logic                       out_ack;

	integer     seed = 45960;
	// expected {rule, tag} pairs in send order
	logic [9:0] expected_q [$];

	match_block i_match_block (
		.clock     (clock),
		.rst       (rst),
		.in_data   (in_data),
		.in_sop    (in_sop),
		.in_eop    (in_eop),
		.in_tag    (in_tag),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_rule  (out_rule),
		.out_tag   (out_tag),
		.out_valid (out_valid),
		.out_ack   (out_ack)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
			abort_run("value mismatch");
		end
	endtask

	// first matching rule in priority order and -1 for a dropped packet
	function automatic int expected_rule(input logic [15:0] ethertype,
			input logic [7:0] protocol, input logic [31:0] dst_ip, input logic [15:0] dst_port);
		if (ethertype == 16'h0800 && protocol == 8'd6 && dst_port == 16'd80)
			return 0;
		if (ethertype == 16'h0800 && protocol == 8'd17 && dst_port == 16'd53)
			return 1;
		if (ethertype == 16'h0800 && dst_ip[31:24] == 8'd10)
			return 2;
		if (ethertype == 16'h0806)
			return 3;
		return -1;
	endfunction

	// ------------------------------
	// stimulus and response
	// ------------------------------
	task automatic send_packet(input logic [7:0] tag, input logic [15:0] ethertype,
			input logic [7:0] protocol, input logic [31:0] src_ip, input logic [31:0] dst_ip,
			input logic [15:0] dst_port, input int beats);
		logic [7:0]   pkt [48];
		logic [127:0] data;
		logic [7:0]   seen_proto;
		logic [31:0]  seen_dst;
		logic [15:0]  seen_port;
		int           rule;
		for (int i = 0; i < 48; i++)
			pkt[i] = 8'($random(seed));
		pkt[12] = ethertype[15:8];
		pkt[13] = ethertype[7:0];
		pkt[23] = protocol;
		for (int k = 0; k < 4; k++) begin
			pkt[26 + k] = src_ip[31 - 8 * k -: 8];
			pkt[30 + k] = dst_ip[31 - 8 * k -: 8];
		end
		pkt[36] = dst_port[15:8];
		pkt[37] = dst_port[7:0];
		for (int b = 0; b < beats; b++) begin
			for (int i = 0; i < 16; i++)
				data[127 - 8 * i -: 8] = pkt[16 * b + i];
			in_data  = data;
			in_sop   = (b == 0);
			in_eop   = (b == beats - 1);
			in_tag   = tag;
			in_valid = 1'b1;
			while (!in_ready)
				@(negedge clock);
			@(negedge clock);
		end
		in_valid = 1'b0;
		in_sop   = 1'b0;
		in_eop   = 1'b0;
		// fields in beats that never arrived read as zero
		seen_proto = (beats > 1) ? protocol : 8'd0;
		seen_dst   = {(beats > 1) ? dst_ip[31:16] : 16'd0, (beats > 2) ? dst_ip[15:0] : 16'd0};
		seen_port  = (beats > 2) ? dst_port : 16'd0;
		rule = expected_rule(ethertype, seen_proto, seen_dst, seen_port);
		if (rule >= 0)
			expected_q.push_back({rule[1:0], tag});
	endtask

	task automatic expect_result();
		logic [9:0] expected;
		while (!out_valid)
			@(negedge clock);
		if (expected_q.size() == 0)
			abort_run("result appeared with none expected");
		expected = expected_q.pop_front();
		check_value("out_rule", expected[9:8], out_rule);
		check_value("out_tag", expected[7:0], out_tag);
		out_ack = 1'b1;
		@(negedge clock);
		out_ack = 1'b0;
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic idle_after_reset();
		check_value("in_ready", 1, in_ready);
		check_value("out_valid", 0, out_valid);
	endtask

	task automatic one_packet_per_rule();
		send_packet(8'h10, 16'h0800, 8'd6, 32'hc0a8_0001, 32'hc0a8_0002, 16'd80, 3);
		send_packet(8'h11, 16'h0800, 8'd17, 32'hc0a8_0003, 32'h0808_0808, 16'd53, 3);
		send_packet(8'h12, 16'h0800, 8'd1, 32'hc0a8_0004, 32'h0a20_3040, 16'd0, 3);
		send_packet(8'h13, 16'h0806, 8'd0, 32'hc0a8_0005, 32'hc0a8_0006, 16'd0, 3);
		repeat (4)
			expect_result();
	endtask

	task automatic unmatched_packet_dropped();
		send_packet(8'h20, 16'h0800, 8'd17, 32'hc0a8_0001, 32'hc0a8_0101, 16'd99, 3);
		send_packet(8'h21, 16'h0800, 8'd17, 32'hc0a8_0001, 32'h0101_0101, 16'd53, 3);
		expect_result();
	endtask

	task automatic overlapping_rules();
		send_packet(8'h30, 16'h0800, 8'd6, 32'hc0a8_0001, 32'h0a01_0203, 16'd80, 3);
		expect_result();
	endtask

	task automatic single_beat_arp();
		send_packet(8'h40, 16'h0806, 8'd0, 32'h0, 32'h0, 16'd0, 1);
		expect_result();
	endtask

	task automatic drain_after_backpressure();
		for (int n = 0; n < 12; n++)
			send_packet(8'h50 + 8'(n), 16'h0800, 8'd6, 32'hc0a8_0001, 32'hc0a8_0002, 16'd80, 3);
		repeat (12)
			expect_result();
		repeat (20)
			@(negedge clock);
		check_value("out_valid", 0, out_valid);
	endtask

	initial begin
		#(TEST_CYCLES * CLK_PERIOD);
		abort_run("watchdog timeout, results missing");
	end

	initial begin
		rst      = 1'b1;
		in_data  = '0;
		in_sop   = 1'b0;
		in_eop   = 1'b0;
		in_tag   = '0;
		in_valid = 1'b0;
		out_ack  = 1'b0;
		repeat (5)
			@(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		@(negedge clock);
		idle_after_reset();
		one_packet_per_rule();
		unmatched_packet_dropped();
		overlapping_rules();
		single_beat_arp();
		drain_after_backpressure();
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- filelist.f
design/classifier_pkg.sv
design/header_if.sv
design/header_capture.sv
design/sync_fifo.sv
design/rule_matcher.sv
design/match_block.sv
bench/match_block_assert.sv
bench/match_block_tb.sv

//--- Makefile
TOP = match_block_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir

# pass only when the pass message shows up in the output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
